// File: compile.f
+incdir+.
dm_pkg.sv
board_reset.sv
dbg_host_if.sv
dm_mem.sv
tile_dm_board.sv
tile_dm_board_assert.sv
tb_tile_dm_board.sv

// File: Bender.yml
package:
  name: tile_dm_board

sources:
  - include_dirs:
      - .
    files:
      - dm_pkg.sv
      - board_reset.sv
      - dbg_host_if.sv
      - dm_mem.sv
      - tile_dm_board.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tile_dm_board_assert.sv
      - tb_tile_dm_board.sv

// File: tb_tile_dm_board.sv
`default_nettype none

`include "dm_defs.svh"

module tb_tile_dm_board
   import dm_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT = 200;

   logic      clk;
   logic      reset_i;
   dbg_word_t host_in;
   logic      host_in_valid;
   logic      host_in_ready;
   dbg_word_t host_out;
   logic      host_out_valid;
   logic      host_out_ready;
   logic      sys_rst;
   logic      cpu_rst;

   integer seed = 32'haa90;
   // Own stream for back-pressure
   integer bp_seed = 32'haa90 + 1;

   // Reference model state
   logic [`DM_DATA_WIDTH-1:0] model_mem [`DM_MEM_WORDS];
   logic [`DM_ADDR_WIDTH-1:0] written_q [$];
   logic                      cpu_hold_model;
   dbg_word_t                 exp_q [$];
   dbg_word_t                 recv_q [$];
   int                        checks;
   int                        errors;
   int                        timeouts;

   tile_dm_board uut (
      .clk              (clk),
      .reset_i          (reset_i),
      .host_in_i        (host_in),
      .host_in_valid_i  (host_in_valid),
      .host_in_ready_o  (host_in_ready),
      .host_out_o       (host_out),
      .host_out_valid_o (host_out_valid),
      .host_out_ready_i (host_out_ready),
      .sys_rst_o        (sys_rst),
      .cpu_rst_o        (cpu_rst)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      host_out_ready <= ($random(bp_seed) & 3) != 0;
   end

   // Reply words that transfer on the coming rising edge
   always @(negedge clk) begin
      if (!reset_i && host_out_valid && host_out_ready) begin
         recv_q.push_back(host_out);
      end
   end

   task automatic check_word(input string name, input dbg_word_t exp, input dbg_word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   function automatic dbg_word_t make_hdr(input logic [3:0] cmd,
                                          input logic [`DM_ADDR_WIDTH-1:0] arg);
      dbg_word_t w;
      w.hdr.cmd = cmd;
      w.hdr.arg = arg;
      return w;
   endfunction

   task automatic send_word(input dbg_word_t w);
      int t;
      host_in       <= w;
      host_in_valid <= 1'b1;
      t = 0;
      do begin
         @(posedge clk);
         t++;
      end while (!host_in_ready && t < TIMEOUT);
      host_in_valid <= 1'b0;
      if (!host_in_ready) begin
         timeouts++;
         $display("ERROR: host link never accepted word %h", w);
      end
   endtask

   // Send one command, predict its replies and reset effects, then check them
   task automatic exec_cmd(input logic [3:0] cmd, input logic [`DM_ADDR_WIDTH-1:0] arg,
                           input logic [`DM_DATA_WIDTH-1:0] data);
      dbg_word_t w;
      dbg_word_t exp;
      logic      bad;
      logic      exp_sys;
      int        t;
      string     name;
      name = $sformatf("cmd %h arg %h", cmd, arg);
      bad = !(cmd inside {CMD_WRITE, CMD_READ, CMD_CPU_RST, CMD_SYS_RST}) ||
            ((cmd == CMD_WRITE || cmd == CMD_READ) && arg >= `DM_MEM_WORDS);
      send_word(make_hdr(cmd, arg));
      if (cmd == CMD_WRITE) begin
         w.raw = data[`DM_DATA_WIDTH-1 -: `DM_WORD_WIDTH];
         send_word(w);
         w.raw = data[`DM_WORD_WIDTH-1:0];
         send_word(w);
      end
      exp_q.push_back(make_hdr(cmd, bad));
      if (cmd == CMD_WRITE && !bad) begin
         model_mem[arg] = data;
         written_q.push_back(arg);
      end
      if (cmd == CMD_READ && !bad) begin
         w.raw = model_mem[arg][`DM_DATA_WIDTH-1 -: `DM_WORD_WIDTH];
         exp_q.push_back(w);
         w.raw = model_mem[arg][`DM_WORD_WIDTH-1:0];
         exp_q.push_back(w);
      end
      if (cmd == CMD_CPU_RST) begin
         cpu_hold_model = arg[0];
      end
      if (cmd == CMD_SYS_RST) begin
         // Request pulse follows acceptance and the reset window follows the pulse
         for (int i = 1; i <= `DM_RST_HOLD + 2; i++) begin
            @(posedge clk);
            exp_sys = (i >= 2) && (i <= `DM_RST_HOLD + 1);
            check_level($sformatf("%s sys_rst cycle %0d", name, i), exp_sys, sys_rst);
            check_level($sformatf("%s cpu_rst cycle %0d", name, i),
                        exp_sys | cpu_hold_model, cpu_rst);
         end
      end
      while (exp_q.size() > 0) begin
         exp = exp_q.pop_front();
         t = 0;
         while (recv_q.size() == 0 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            // No new command word while a reply is pending
            check_level({name, " in ready while busy"}, 1'b0, host_in_ready);
         end
         if (recv_q.size() == 0) begin
            timeouts++;
            $display("ERROR: %s: reply word %h never arrived", name, exp);
            exp_q.delete();
         end else begin
            check_word(name, exp, recv_q.pop_front());
         end
      end
      check_level({name, " sys_rst"}, 1'b0, sys_rst);
      check_level({name, " cpu_rst"}, cpu_hold_model, cpu_rst);
   endtask

   initial begin
      int                        sel;
      int                        t;
      int                        assert_fails;
      logic [3:0]                code;
      logic [`DM_ADDR_WIDTH-1:0] arg;
      logic [`DM_DATA_WIDTH-1:0] data;
      reset_i        = 1'b1;
      host_in        = '0;
      host_in_valid  = 1'b0;
      host_out_ready = 1'b0;
      cpu_hold_model = 1'b0;
      repeat (4) @(posedge clk);
      reset_i <= 1'b0;
      @(posedge clk);
      check_level("in ready after reset", 1'b1, host_in_ready);
      check_level("out valid after reset", 1'b0, host_out_valid);

      // Board reset window runs out first
      t = 0;
      while (sys_rst && t < TIMEOUT) begin
         @(posedge clk);
         t++;
      end
      if (sys_rst) begin
         timeouts++;
         $display("ERROR: sys_rst stayed high after board reset");
      end

      exec_cmd(CMD_WRITE, 12'h005, 32'hcafe_0123);
      exec_cmd(CMD_READ, 12'h005, '0);
      exec_cmd(CMD_WRITE, 12'h0ff, 32'h1234_5678);
      exec_cmd(CMD_READ, 12'h0ff, '0);
      exec_cmd(CMD_READ, 12'h100, '0);
      exec_cmd(CMD_WRITE, 12'hfff, 32'hdead_beef);
      exec_cmd(4'h0, 12'h000, '0);
      exec_cmd(4'hf, 12'h123, '0);
      exec_cmd(CMD_CPU_RST, 12'h001, '0);
      exec_cmd(CMD_READ, 12'h005, '0);
      exec_cmd(CMD_CPU_RST, 12'h000, '0);
      exec_cmd(CMD_SYS_RST, 12'h000, '0);
      exec_cmd(CMD_READ, 12'h005, '0);
      exec_cmd(CMD_READ, 12'h0ff, '0);

      for (int n = 0; n < 200; n++) begin
         sel  = {$random(seed)} % 16;
         arg  = $random(seed);
         data = $random(seed);
         if (sel < 7) begin
            exec_cmd(CMD_WRITE, (sel == 0) ? (arg | `DM_MEM_WORDS) : (arg % `DM_MEM_WORDS),
                     data);
         end else if (sel < 12) begin
            exec_cmd(CMD_READ, (sel == 7) ? (arg | `DM_MEM_WORDS) :
                     written_q[{$random(seed)} % written_q.size()], data);
         end else if (sel == 12) begin
            code = 4'({$random(seed)} % 12);
            if (code != 4'd0) begin
               code = code + 4'd4;
            end
            exec_cmd(code, arg, data);
         end else if (sel < 15) begin
            exec_cmd(CMD_CPU_RST, arg, data);
         end else begin
            exec_cmd(CMD_SYS_RST, arg, data);
         end
      end

      if (recv_q.size() != 0) begin
         errors++;
         $display("ERROR: %0d reply words arrived that no command expected", recv_q.size());
      end
      assert_fails = uut.u_dbg_host_if.u_link_assert.fails;

      $display("Summary: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
               checks, errors, timeouts, assert_fails);
      if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tile_dm_board_assert.sv
`default_nettype none

module tile_dm_board_assert
   import dm_pkg::*;
(
   input wire            clk,
   input wire            reset_i,
   input wire dbg_word_t out_word_i,
   input wire            out_valid_i,
   input wire            out_ready_i,
   input wire wb_req_t   wb_req_i,
   input wire wb_rsp_t   wb_rsp_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // Count of failed assertions
   int fails = 0;

   // Reply word holds until the host takes it
   out_stable_a: assert property (@(posedge clk) disable iff (reset_i)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_word_i))
      else begin
         fails++;
         $error("reply word changed before it was accepted");
      end

   // Memory answers on the cycle after the request opens
   rsp_timing_a: assert property (@(posedge clk) disable iff (reset_i)
      $rose(wb_req_i.cyc) |=> (wb_rsp_i.ack || wb_rsp_i.err))
      else begin
         fails++;
         $error("bus response not one cycle after cyc rose");
      end

   rsp_in_cycle_a: assert property (@(posedge clk) disable iff (reset_i)
      (wb_rsp_i.ack || wb_rsp_i.err) |-> wb_req_i.cyc)
      else begin
         fails++;
         $error("bus response outside an open cycle");
      end

   ack_err_a: assert property (@(posedge clk) disable iff (reset_i)
      !(wb_rsp_i.ack && wb_rsp_i.err))
      else begin
         fails++;
         $error("ack and err both high");
      end

endmodule

bind dbg_host_if tile_dm_board_assert u_link_assert (
   .clk         (clk),
   .reset_i     (reset_i),
   .out_word_i  (host_out_o),
   .out_valid_i (host_out_valid_o),
   .out_ready_i (host_out_ready_i),
   .wb_req_i    (wb_req_o),
   .wb_rsp_i    (wb_rsp_i)
);

`default_nettype wire

// File: tile_dm_board.sv
`default_nettype none

module tile_dm_board
   import dm_pkg::*;
(
   input  wire            clk,
   input  wire            reset_i,

   // Host link
   input  wire dbg_word_t host_in_i,
   input  wire            host_in_valid_i,
   output logic           host_in_ready_o,
   output dbg_word_t      host_out_o,
   output logic           host_out_valid_o,
   input  wire            host_out_ready_i,

   // Resets handed to the compute tile
   output logic           sys_rst_o,
   output logic           cpu_rst_o
);

   wb_req_t wb_req;
   wb_rsp_t wb_rsp;
   logic    sys_req;
   logic    cpu_hold;

   board_reset u_board_reset (
      .clk        (clk),
      .reset_i    (reset_i),
      .sys_req_i  (sys_req),
      .cpu_hold_i (cpu_hold),
      .sys_rst_o  (sys_rst_o),
      .cpu_rst_o  (cpu_rst_o)
   );

   // Debug side stays on the board reset only
   dbg_host_if u_dbg_host_if (
      .clk              (clk),
      .reset_i          (reset_i),
      .host_in_i        (host_in_i),
      .host_in_valid_i  (host_in_valid_i),
      .host_in_ready_o  (host_in_ready_o),
      .host_out_o       (host_out_o),
      .host_out_valid_o (host_out_valid_o),
      .host_out_ready_i (host_out_ready_i),
      .wb_req_o         (wb_req),
      .wb_rsp_i         (wb_rsp),
      .sys_req_o        (sys_req),
      .cpu_hold_o       (cpu_hold)
   );

   dm_mem u_dm_mem (
      .clk      (clk),
      .reset_i  (reset_i),
      .wb_req_i (wb_req),
      .wb_rsp_o (wb_rsp)
   );

endmodule

`default_nettype wire

// File: dm_mem.sv
`default_nettype none

`include "dm_defs.svh"

module dm_mem
   import dm_pkg::*;
(
   input  wire          clk,
   input  wire          reset_i,

   input  wire wb_req_t wb_req_i,
   output wb_rsp_t      wb_rsp_o
);

   localparam int IDX_W = $clog2(`DM_MEM_WORDS);

   logic [`DM_DATA_WIDTH-1:0] mem [`DM_MEM_WORDS];
   logic [`DM_DATA_WIDTH-1:0] rdat_q;
   logic [IDX_W-1:0]          idx;
   logic                      cyc_q;
   logic                      ack_q;
   logic                      err_q;
   logic                      start;
   logic                      in_range;

   // Serve each cycle once, on its first clock
   assign start    = wb_req_i.cyc && !cyc_q;
   assign in_range = (wb_req_i.adr < `DM_MEM_WORDS);
   assign idx      = wb_req_i.adr[IDX_W-1:0];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         cyc_q <= 1'b0;
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         cyc_q <= wb_req_i.cyc;
         ack_q <= start && in_range;
         err_q <= start && !in_range;
      end
   end

   always_ff @(posedge clk) begin
      if (start && in_range) begin
         if (wb_req_i.we) begin
            for (int b = 0; b < `DM_DATA_WIDTH/8; b++) begin
               if (wb_req_i.sel[b]) begin
                  mem[idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
               end
            end
         end
         rdat_q <= mem[idx];
      end
   end

   assign wb_rsp_o = '{ack: ack_q, err: err_q, dat: rdat_q};

endmodule

`default_nettype wire

// File: dbg_host_if.sv
`default_nettype none

`include "dm_defs.svh"

module dbg_host_if
   import dm_pkg::*;
(
   input  wire            clk,
   input  wire            reset_i,

   // Command words from the host
   input  wire dbg_word_t host_in_i,
   input  wire            host_in_valid_i,
   output logic           host_in_ready_o,

   // Reply words to the host
   output dbg_word_t      host_out_o,
   output logic           host_out_valid_o,
   input  wire            host_out_ready_i,

   // Memory bus
   output wb_req_t        wb_req_o,
   input  wire wb_rsp_t   wb_rsp_i,

   // Reset control
   output logic           sys_req_o,
   output logic           cpu_hold_o
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WR_HI,
      ST_WR_LO,
      ST_BUS,
      ST_REPLY
   } state_e;

   state_e                    state_q;
   dbg_hdr_t                  hdr_q;
   logic [`DM_DATA_WIDTH-1:0] wdata_q;
   logic [`DM_DATA_WIDTH-1:0] rdata_q;
   logic                      cyc_q;
   logic                      err_q;
   logic [1:0]                idx_q;
   logic [1:0]                last_idx_q;
   logic                      sys_req_q;
   logic                      cpu_hold_q;
   logic                      in_fire;
   logic                      out_fire;
   logic                      bus_done;

   // Input is only taken while no reply is pending
   assign host_in_ready_o = (state_q == ST_IDLE) || (state_q == ST_WR_HI) ||
                            (state_q == ST_WR_LO);
   assign in_fire = host_in_valid_i && host_in_ready_o;

   assign host_out_valid_o = (state_q == ST_REPLY);
   assign out_fire = host_out_valid_o && host_out_ready_i;

   assign bus_done = wb_rsp_i.ack || wb_rsp_i.err;

   // Reply word 0 is the header, then read data high and low
   always_comb begin
      case (idx_q)
         2'd1: host_out_o.raw = rdata_q[`DM_DATA_WIDTH-1 -: `DM_WORD_WIDTH];
         2'd2: host_out_o.raw = rdata_q[`DM_WORD_WIDTH-1:0];
         default: begin
            host_out_o.hdr.cmd = hdr_q.cmd;
            host_out_o.hdr.arg = {{(`DM_ADDR_WIDTH-1){1'b0}}, err_q};
         end
      endcase
   end

   assign wb_req_o = '{cyc: cyc_q,
                       we:  (hdr_q.cmd == CMD_WRITE),
                       adr: hdr_q.arg,
                       dat: wdata_q,
                       sel: {(`DM_DATA_WIDTH/8){1'b1}}};

   assign sys_req_o  = sys_req_q;
   assign cpu_hold_o = cpu_hold_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q    <= ST_IDLE;
         cyc_q      <= 1'b0;
         err_q      <= 1'b0;
         idx_q      <= 2'd0;
         last_idx_q <= 2'd0;
         sys_req_q  <= 1'b0;
         cpu_hold_q <= 1'b0;
      end else begin
         sys_req_q <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               if (in_fire) begin
                  err_q      <= 1'b0;
                  idx_q      <= 2'd0;
                  last_idx_q <= 2'd0;
                  case (host_in_i.hdr.cmd)
                     CMD_WRITE: state_q <= ST_WR_HI;
                     CMD_READ: begin
                        cyc_q   <= 1'b1;
                        state_q <= ST_BUS;
                     end
                     CMD_CPU_RST: begin
                        cpu_hold_q <= host_in_i.hdr.arg[0];
                        state_q    <= ST_REPLY;
                     end
                     CMD_SYS_RST: begin
                        sys_req_q <= 1'b1;
                        state_q   <= ST_REPLY;
                     end
                     default: begin
                        err_q   <= 1'b1;
                        state_q <= ST_REPLY;
                     end
                  endcase
               end
            end
            ST_WR_HI: begin
               if (in_fire) begin
                  state_q <= ST_WR_LO;
               end
            end
            ST_WR_LO: begin
               // Payload complete, the write goes out with it
               if (in_fire) begin
                  cyc_q   <= 1'b1;
                  state_q <= ST_BUS;
               end
            end
            ST_BUS: begin
               if (bus_done) begin
                  cyc_q   <= 1'b0;
                  err_q   <= wb_rsp_i.err;
                  state_q <= ST_REPLY;
                  if (!wb_rsp_i.err && (hdr_q.cmd == CMD_READ)) begin
                     last_idx_q <= 2'd2;
                  end
               end
            end
            ST_REPLY: begin
               if (out_fire) begin
                  if (idx_q == last_idx_q) begin
                     state_q <= ST_IDLE;
                  end else begin
                     idx_q <= idx_q + 2'd1;
                  end
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Command payload
   always_ff @(posedge clk) begin
      if (in_fire && (state_q == ST_IDLE)) begin
         hdr_q <= host_in_i.hdr;
      end
      if (in_fire && (state_q == ST_WR_HI)) begin
         wdata_q[`DM_DATA_WIDTH-1 -: `DM_WORD_WIDTH] <= host_in_i.raw;
      end
      if (in_fire && (state_q == ST_WR_LO)) begin
         wdata_q[`DM_WORD_WIDTH-1:0] <= host_in_i.raw;
      end
      if ((state_q == ST_BUS) && wb_rsp_i.ack) begin
         rdata_q <= wb_rsp_i.dat;
      end
   end

endmodule

`default_nettype wire

// File: board_reset.sv
`default_nettype none

`include "dm_defs.svh"

module board_reset (
   input  wire  clk,
   input  wire  reset_i,

   // Requests from the debug host
   input  wire  sys_req_i,
   input  wire  cpu_hold_i,

   output logic sys_rst_o,
   output logic cpu_rst_o
);

   localparam int CNT_W = $clog2(`DM_RST_HOLD + 1);

   logic [CNT_W-1:0] hold_cnt_q;

   // Board reset and debug requests both restart the hold window
   always_ff @(posedge clk) begin
      if (reset_i || sys_req_i) begin
         hold_cnt_q <= CNT_W'(`DM_RST_HOLD);
      end else if (hold_cnt_q != '0) begin
         hold_cnt_q <= hold_cnt_q - 1'b1;
      end
   end

   assign sys_rst_o = (hold_cnt_q != '0);

   // CPU is held by any system reset as well
   assign cpu_rst_o = sys_rst_o | cpu_hold_i;

endmodule

`default_nettype wire

// File: dm_pkg.sv
`default_nettype none

`include "dm_defs.svh"

package dm_pkg;

   // Host command codes, other values are rejected
   typedef enum logic [3:0] {
      CMD_WRITE   = 4'h1,
      CMD_READ    = 4'h2,
      CMD_CPU_RST = 4'h3,
      CMD_SYS_RST = 4'h4
   } dbg_cmd_e;

   typedef struct packed {
      logic [3:0]                cmd;
      logic [`DM_ADDR_WIDTH-1:0] arg;
   } dbg_hdr_t;

   // One link word, either a command header or raw payload
   typedef union packed {
      dbg_hdr_t                  hdr;
      logic [`DM_WORD_WIDTH-1:0] raw;
   } dbg_word_t;

   typedef struct packed {
      logic                        cyc;
      logic                        we;
      logic [`DM_ADDR_WIDTH-1:0]   adr;
      logic [`DM_DATA_WIDTH-1:0]   dat;
      logic [`DM_DATA_WIDTH/8-1:0] sel;
   } wb_req_t;

   typedef struct packed {
      logic                      ack;
      logic                      err;
      logic [`DM_DATA_WIDTH-1:0] dat;
   } wb_rsp_t;

endpackage

`default_nettype wire

// File: dm_defs.svh
`ifndef DM_DEFS_SVH
`define DM_DEFS_SVH

// Host link word and memory data widths
`define DM_WORD_WIDTH 16
`define DM_DATA_WIDTH 32

// Word address, sized to fit a header argument
`define DM_ADDR_WIDTH 12

// Implemented RAM depth in words
`define DM_MEM_WORDS 256

// Cycles a debug system reset is held
`define DM_RST_HOLD 8

`endif
